//--- hdl/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    // ########################################################################
    // packet and field widths of the tree
    // ########################################################################

    localparam int LEAF_W    = 5;
    localparam int PORT_W    = 4;
    localparam int ADDR_W    = 7;
    localparam int PAYLOAD_W = 32;

    typedef struct packed {
        logic                 vld;       // set when a packet is present.
        logic [LEAF_W-1:0]    dest_leaf;
        logic [PORT_W-1:0]    dest_port; // ports count from 1.
        logic [ADDR_W-1:0]    addr;
        logic [PAYLOAD_W-1:0] payload;
    } bft_packet_t;

    typedef logic [PAYLOAD_W-1:0] word_t;

    typedef struct packed {
        logic [ADDR_W-1:0]    seq;       // word count modulo 128.
        logic [PAYLOAD_W-1:0] sum;       // running sum of the port.
    } out_entry_t;

    typedef struct packed {
        logic [LEAF_W-1:0] leaf;
        logic [PORT_W-1:0] port;
    } route_t;

    // ########################################################################
    // configuration registers
    // ########################################################################

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CTRL       = 8'h00; // bit 0 is enable.
    localparam apb_addr_t REG_ROUTE_BASE = 8'h04; // one word per output port.
    localparam apb_addr_t REG_DROP_CNT   = 8'h10; // read only.

endpackage

`default_nettype wire

//--- hdl/stream_fifo.sv
`default_nettype none

module stream_fifo #(
    parameter type item_t = logic [31:0],
    parameter int  DEPTH  = 4
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  wr_valid,
    output logic       wr_ready,
    input  wire item_t wr_data,
    output logic       rd_valid,
    input  wire logic  rd_ready,
    output item_t      rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr]; // head is shown ahead of the read.
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) wr_ptr <= next_ptr(wr_ptr);
            if (rd_fire) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

//--- hdl/leaf_config_apb.sv
`default_nettype none

module leaf_config_apb import leaf_pkg::*; #(
    parameter int NUM_PORTS = 3
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire apb_addr_t              paddr,
    input  wire apb_data_t              pwdata,
    output apb_data_t                   prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  wire logic [15:0]            drop_cnt,
    output logic                        enable,
    output route_t [NUM_PORTS-1:0]      routes
);

    logic                 access;
    logic                 hit_ctrl;
    logic                 hit_drop;
    logic [NUM_PORTS-1:0] hit_route;
    logic                 bad;
    logic                 wr_en;
    apb_data_t            rd_mux;

    always_comb begin
        hit_ctrl = (paddr == REG_CTRL);
        hit_drop = (paddr == REG_DROP_CNT);
        rd_mux   = '0;
        if (hit_ctrl) rd_mux = {31'b0, enable};
        for (int k = 0; k < NUM_PORTS; k++) begin
            hit_route[k] = (paddr == REG_ROUTE_BASE + apb_addr_t'(4 * k));
            if (hit_route[k]) rd_mux = {20'b0, routes[k].port, 3'b0, routes[k].leaf};
        end
        if (hit_drop) rd_mux = {16'b0, drop_cnt};
    end

    assign access  = psel && penable;
    assign bad     = !(hit_ctrl || hit_drop || (|hit_route)) || (pwrite && hit_drop);
    assign wr_en   = access && pwrite && !bad;
    assign pready  = access; // no wait states.
    assign pslverr = access && bad;
    assign prdata  = rd_mux;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
            routes <= '0;
        end else if (wr_en) begin
            if (hit_ctrl) enable <= pwdata[0];
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (hit_route[k]) begin
                    routes[k].leaf <= pwdata[4:0];
                    routes[k].port <= pwdata[11:8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/packet_ingress.sv
`default_nettype none

module packet_ingress import leaf_pkg::*; #(
    parameter logic [LEAF_W-1:0] LEAF_ID    = 5'd3,
    parameter int                NUM_PORTS  = 3,
    parameter int                FIFO_DEPTH = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire bft_packet_t          din,
    output logic [NUM_PORTS-1:0]      in_valid,
    input  wire logic [NUM_PORTS-1:0] in_ready,
    output word_t [NUM_PORTS-1:0]     in_word,
    output logic [15:0]               drop_cnt
);

    logic                 leaf_hit;
    logic [NUM_PORTS-1:0] wr_valid;
    logic [NUM_PORTS-1:0] wr_ready;
    logic                 accepted;
    logic                 drop;

    assign leaf_hit = din.vld && (din.dest_leaf == LEAF_ID);

    // ########################################################################
    // one input FIFO per port, steered by dest_port
    // ########################################################################

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign wr_valid[i] = leaf_hit && (din.dest_port == PORT_W'(i + 1));

        stream_fifo #(
            .item_t (word_t),
            .DEPTH  (FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_valid (wr_valid[i]),
            .wr_ready (wr_ready[i]),
            .wr_data  (din.payload),
            .rd_valid (in_valid[i]),
            .rd_ready (in_ready[i]),
            .rd_data  (in_word[i])
        );
    end

    // port 0, ports above NUM_PORTS and full FIFOs all end up here.
    assign accepted = |(wr_valid & wr_ready);
    assign drop     = din.vld && !accepted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt <= '0;
        end else if (drop && (drop_cnt != 16'hffff)) begin
            drop_cnt <= drop_cnt + 1'b1; // saturates.
        end
    end

endmodule

`default_nettype wire

//--- hdl/user_kernel.sv
`default_nettype none

module user_kernel import leaf_pkg::*; #(
    parameter int NUM_PORTS = 3
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  enable,
    input  wire logic [NUM_PORTS-1:0]  in_valid,
    output logic [NUM_PORTS-1:0]       in_ready,
    input  wire word_t [NUM_PORTS-1:0] in_word,
    output logic [NUM_PORTS-1:0]       out_valid,
    input  wire logic [NUM_PORTS-1:0]  out_ready,
    output out_entry_t [NUM_PORTS-1:0] out_entry
);

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        word_t             sum_q;
        logic [ADDR_W-1:0] cnt_q;
        logic              valid_q;
        out_entry_t        entry_q;
        logic              accept;
        word_t             next_sum;

        // the output register takes a word when empty or being emptied.
        assign in_ready[i] = enable && (!valid_q || out_ready[i]);
        assign accept      = in_valid[i] && in_ready[i];
        assign next_sum    = sum_q + in_word[i];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sum_q   <= '0;
                cnt_q   <= '0;
                valid_q <= 1'b0;
            end else if (accept) begin
                sum_q   <= next_sum;
                cnt_q   <= cnt_q + 1'b1; // wraps at 128.
                valid_q <= 1'b1;
            end else if (out_ready[i]) begin
                valid_q <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (accept) begin
                entry_q.seq <= cnt_q;
                entry_q.sum <= next_sum;
            end
        end

        assign out_valid[i] = valid_q;
        assign out_entry[i] = entry_q;
    end

endmodule

`default_nettype wire

//--- hdl/packet_egress.sv
`default_nettype none

module packet_egress import leaf_pkg::*; #(
    parameter int NUM_PORTS  = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [NUM_PORTS-1:0]       out_valid,
    output logic [NUM_PORTS-1:0]            out_ready,
    input  wire out_entry_t [NUM_PORTS-1:0] out_entry,
    input  wire route_t [NUM_PORTS-1:0]     routes,
    input  wire logic                       resend,
    output bft_packet_t                     dout
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [NUM_PORTS-1:0]       head_valid;
    logic [NUM_PORTS-1:0]       head_ready;
    out_entry_t [NUM_PORTS-1:0] head;
    logic [IDX_W-1:0]           sel;
    logic [IDX_W-1:0]           last_q;
    logic                       found;
    logic                       load;
    bft_packet_t                pkt_q;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign head_ready[i] = load && (sel == IDX_W'(i));

        stream_fifo #(
            .item_t (out_entry_t),
            .DEPTH  (FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_valid (out_valid[i]),
            .wr_ready (out_ready[i]),
            .wr_data  (out_entry[i]),
            .rd_valid (head_valid[i]),
            .rd_ready (head_ready[i]),
            .rd_data  (head[i])
        );
    end

    // ########################################################################
    // round robin, starting after the last port granted
    // ########################################################################

    always_comb begin
        int idx;
        sel   = last_q;
        found = 1'b0;
        for (int off = 1; off <= NUM_PORTS; off++) begin
            idx = (int'(last_q) + off) % NUM_PORTS;
            if (!found && head_valid[idx]) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    // the packet register is refilled when empty or taken by the tree.
    assign load = found && (!pkt_q.vld || !resend);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_q  <= '0;
            last_q <= IDX_W'(NUM_PORTS - 1); // port 0 wins first.
        end else if (load) begin
            pkt_q.vld       <= 1'b1;
            pkt_q.dest_leaf <= routes[sel].leaf;
            pkt_q.dest_port <= routes[sel].port;
            pkt_q.addr      <= head[sel].seq;
            pkt_q.payload   <= head[sel].sum;
            last_q          <= sel;
        end else if (pkt_q.vld && !resend) begin
            pkt_q.vld <= 1'b0;
        end
    end

    assign dout = resend ? '0 : pkt_q; // held packet is hidden during resend.

endmodule

`default_nettype wire

//--- hdl/leaf_top.sv
`default_nettype none

module leaf_top import leaf_pkg::*; #(
    parameter logic [LEAF_W-1:0] LEAF_ID    = 5'd3,
    parameter int                NUM_PORTS  = 3,
    parameter int                FIFO_DEPTH = 4
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire bft_packet_t din,
    output bft_packet_t      dout,
    input  wire logic        resend,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire apb_addr_t   paddr,
    input  wire apb_data_t   pwdata,
    output apb_data_t        prdata,
    output logic             pready,
    output logic             pslverr
);

    logic [NUM_PORTS-1:0]       in_valid;
    logic [NUM_PORTS-1:0]       in_ready;
    word_t [NUM_PORTS-1:0]      in_word;
    logic [NUM_PORTS-1:0]       out_valid;
    logic [NUM_PORTS-1:0]       out_ready;
    out_entry_t [NUM_PORTS-1:0] out_entry;
    route_t [NUM_PORTS-1:0]     routes;
    logic                       enable;
    logic [15:0]                drop_cnt;

    leaf_config_apb #(.NUM_PORTS(NUM_PORTS)) u_config (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .drop_cnt(drop_cnt), .enable(enable), .routes(routes)
    );

    packet_ingress #(
        .LEAF_ID    (LEAF_ID),
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ingress (
        .clk(clk), .rst_n(rst_n), .din(din),
        .in_valid(in_valid), .in_ready(in_ready), .in_word(in_word),
        .drop_cnt(drop_cnt)
    );

    user_kernel #(.NUM_PORTS(NUM_PORTS)) u_kernel (
        .clk(clk), .rst_n(rst_n), .enable(enable),
        .in_valid(in_valid), .in_ready(in_ready), .in_word(in_word),
        .out_valid(out_valid), .out_ready(out_ready), .out_entry(out_entry)
    );

    packet_egress #(
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_egress (
        .clk(clk), .rst_n(rst_n),
        .out_valid(out_valid), .out_ready(out_ready), .out_entry(out_entry),
        .routes(routes), .resend(resend), .dout(dout)
    );

endmodule

`default_nettype wire

//--- tests/leaf_sva.sv
`default_nettype none

module leaf_sva import leaf_pkg::*; (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        psel,
    input wire logic        penable,
    input wire logic        pready,
    input wire logic        resend,
    input wire bft_packet_t dout,
    input wire bft_packet_t held     // egress packet register.
);

    timeunit 1ns;
    timeprecision 1ps;

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pready)
        else $error("pready was low in an APB access phase.");

    a_dout_hidden: assert property (@(posedge clk) disable iff (!rst_n)
        resend |-> (dout == '0))
        else $error("dout was not zero while resend was high.");

    // the register may only change on a cycle where resend is low.
    a_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (resend && held.vld) |=> $stable(held))
        else $error("held packet changed during a resend burst.");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !dout.vld)
        else $error("dout vld was set during reset.");

endmodule

bind leaf_top leaf_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .resend  (resend),
    .dout    (dout),
    .held    (u_egress.pkt_q)
);

`default_nettype wire

//--- tests/leaf_tb.sv
`default_nettype none

module leaf_tb import leaf_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [LEAF_W-1:0] LEAF_ID = 5'd3;
    localparam int NUM_PORTS   = 3;
    localparam int FIFO_DEPTH  = 4;
    localparam int NUM_TRAFFIC = 900;
    localparam int NUM_STIM    = NUM_TRAFFIC + FIFO_DEPTH + 2;

    logic        clk;
    logic        rst_n;
    bft_packet_t din;
    bft_packet_t dout;
    logic        resend;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;

    route_t      route_tab [NUM_PORTS];
    word_t       sum_model [NUM_PORTS];
    int unsigned cnt_model [NUM_PORTS];
    bft_packet_t exp_q [NUM_PORTS][$];   // expected packets per output port.
    int unsigned exp_drops;
    int unsigned burst_left;
    logic        bursts_on;
    logic        expect_quiet;           // set while enable is low.

    leaf_top #(
        .LEAF_ID    (LEAF_ID),
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ########################################################################
    // failure reporting and compare tasks
    // ########################################################################

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error.");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_packet(input string name, input bft_packet_t exp,
                                input bft_packet_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_apb(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t data,
                              output apb_data_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #2;
        check_flag("apb pready", 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic drive_cycle(input bft_packet_t pkt);
        @(negedge clk);
        din = pkt;
        if (!bursts_on) burst_left = 0;
        if (bursts_on && burst_left == 0 && $urandom_range(0, 7) == 0)
            burst_left = $urandom_range(1, 6);
        resend = (burst_left != 0);
        if (burst_left != 0) burst_left--;
    endtask

    function automatic bft_packet_t good_packet(input int p);
        bft_packet_t pkt;
        pkt.vld       = 1'b1;
        pkt.dest_leaf = LEAF_ID;
        pkt.dest_port = PORT_W'(p + 1);
        pkt.addr      = ADDR_W'($urandom);
        pkt.payload   = $urandom;
        return pkt;
    endfunction

    function automatic bft_packet_t bad_packet();
        bft_packet_t pkt;
        pkt = good_packet(0);
        case ($urandom_range(0, 2))
            0:       pkt.dest_leaf = LEAF_ID + LEAF_W'($urandom_range(1, 31));
            1:       pkt.dest_port = '0;
            default: pkt.dest_port = PORT_W'($urandom_range(NUM_PORTS + 1, 15));
        endcase
        return pkt;
    endfunction

    task automatic send_good(input int p);
        bft_packet_t pkt;
        bft_packet_t exp;
        pkt          = good_packet(p);
        sum_model[p] = sum_model[p] + pkt.payload;
        exp.vld       = 1'b1;
        exp.dest_leaf = route_tab[p].leaf;
        exp.dest_port = route_tab[p].port;
        exp.addr      = ADDR_W'(cnt_model[p]); // count before this word, modulo 128.
        exp.payload   = sum_model[p];
        cnt_model[p]++;
        exp_q[p].push_back(exp);
        drive_cycle(pkt);
    endtask

    function automatic logic queues_empty();
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (exp_q[k].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int port_of(input bft_packet_t pkt);
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (pkt.dest_leaf == route_tab[k].leaf && pkt.dest_port == route_tab[k].port)
                return k;
        end
        return -1;
    endfunction

    task automatic drain();
        while (!queues_empty()) drive_cycle('0);
        bursts_on = 1'b0;
        drive_cycle('0);
    endtask

    // ########################################################################
    // output monitor and watchdog
    // ########################################################################

    initial begin
        int          k;
        bft_packet_t exp;
        forever begin
            @(negedge clk);
            #2;
            if (rst_n && resend) check_packet("dout during resend", '0, dout);
            if (rst_n && dout.vld && !resend) begin
                k = port_of(dout);
                if (expect_quiet)
                    report_failure("A packet left the leaf while enable was low.");
                else if (k < 0)
                    report_failure("A packet carried a route that no port owns.");
                else if (exp_q[k].size() == 0)
                    report_failure("A packet arrived that the model did not expect.");
                else begin
                    exp = exp_q[k].pop_front();
                    check_packet($sformatf("delivery on port %0d", k), exp, dout);
                end
            end
        end
    end

    initial begin
        repeat (NUM_STIM * 200 + 2000) @(posedge clk);
        report_failure("The run timed out before all packets were delivered.");
    end

    // ########################################################################
    // test sequence
    // ########################################################################

    initial begin
        apb_data_t rdata;
        apb_data_t wdata;
        logic      err;
        int        p;
        bft_packet_t pkt;
        void'($urandom(65));
        rst_n        = 1'b0;
        din          = '0;
        resend       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        burst_left   = 0;
        bursts_on    = 1'b0;
        expect_quiet = 1'b0;
        exp_drops    = 0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            sum_model[k] = '0;
            cnt_model[k] = 0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        check_packet("dout after reset", '0, dout);
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        check_apb("ctrl after reset", '0, rdata);
        p = $urandom_range(0, 15);
        for (int k = 0; k < NUM_PORTS; k++) begin
            route_tab[k].leaf = LEAF_W'($urandom);
            route_tab[k].port = PORT_W'(p + k); // distinct port field per route.
            wdata       = $urandom;
            wdata[4:0]  = route_tab[k].leaf;
            wdata[11:8] = route_tab[k].port;
            apb_access(1'b1, REG_ROUTE_BASE + apb_addr_t'(4 * k), wdata, rdata, err);
            check_flag("route write pslverr", 1'b0, err);
            apb_access(1'b0, REG_ROUTE_BASE + apb_addr_t'(4 * k), '0, rdata, err);
            check_apb("route readback", wdata & 32'h0000_0f1f, rdata);
        end
        apb_access(1'b1, REG_CTRL, $urandom | 32'h1, rdata, err);
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        check_apb("ctrl readback", 32'h1, rdata);
        apb_access(1'b0, 8'h14 + apb_addr_t'($urandom_range(0, 200)), '0, rdata, err);
        check_flag("unmapped read pslverr", 1'b1, err);
        apb_access(1'b1, REG_DROP_CNT, $urandom, rdata, err);
        check_flag("drop counter write pslverr", 1'b1, err);
        apb_access(1'b0, REG_DROP_CNT, '0, rdata, err);
        check_apb("drop count after reset", '0, rdata);

        bursts_on = 1'b1;
        for (int n = 0; n < NUM_TRAFFIC; n++) begin
            p = $urandom_range(0, NUM_PORTS - 1);
            case ($urandom_range(0, 9))
                0, 1: begin
                    pkt     = good_packet(p);
                    pkt.vld = 1'b0;        // fields without vld are ignored.
                    drive_cycle(pkt);
                end
                2, 3: begin
                    drive_cycle(bad_packet());
                    exp_drops++;
                end
                default: begin
                    if (exp_q[p].size() < FIFO_DEPTH) send_good(p);
                    else drive_cycle('0);
                end
            endcase
        end
        drain();
        apb_access(1'b0, REG_DROP_CNT, '0, rdata, err);
        check_apb("drop count after traffic", apb_data_t'(exp_drops), rdata);

        apb_access(1'b1, REG_CTRL, '0, rdata, err);
        expect_quiet = 1'b1;
        p = $urandom_range(0, NUM_PORTS - 1);
        for (int n = 0; n < FIFO_DEPTH; n++) send_good(p);
        for (int n = 0; n < 2; n++) begin
            drive_cycle(good_packet(p)); // input FIFO is full by now.
            exp_drops++;
        end
        repeat (20) drive_cycle('0);
        apb_access(1'b0, REG_DROP_CNT, '0, rdata, err);
        check_apb("drop count with enable low", apb_data_t'(exp_drops), rdata);
        expect_quiet = 1'b0;
        apb_access(1'b1, REG_CTRL, 32'h1, rdata, err);
        bursts_on = 1'b1;
        drain();

        apb_access(1'b0, REG_DROP_CNT, '0, rdata, err);
        check_apb("final drop count", apb_data_t'(exp_drops), rdata);
        if (queues_empty()) begin
            $display("Test OK");
            $finish;
        end else begin
            report_failure("Expected packets were still pending at the end of the run.");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/leaf_pkg.sv
hdl/stream_fifo.sv
hdl/leaf_config_apb.sv
hdl/packet_ingress.sv
hdl/user_kernel.sv
hdl/packet_egress.sv
hdl/leaf_top.sv
tests/leaf_sva.sv
tests/leaf_tb.sv

//--- Bender.yml
package:
  name: bft_leaf

sources:
  - hdl/leaf_pkg.sv
  - hdl/stream_fifo.sv
  - hdl/leaf_config_apb.sv
  - hdl/packet_ingress.sv
  - hdl/user_kernel.sv
  - hdl/packet_egress.sv
  - hdl/leaf_top.sv
  - target: test
    files:
      - tests/leaf_sva.sv
      - tests/leaf_tb.sv
